//--- video_downscale.f
+incdir+include
hw/video_downscale_pkg.sv
hw/dual_port_ram.sv
hw/frame_timing.sv
hw/block_accumulator.sv
hw/strobe_compare.sv
hw/readout_fsm.sv
hw/video_downscale_top.sv
tb/video_downscale_assertions.sv
tb/video_downscale_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= video_downscale_tb
FLIST     ?= video_downscale.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FLIST)) include/video_downscale_consts.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)

//--- tb/video_downscale_tb.sv
// four frames of 324x324 pixels; reference covers the 32x32 grid of the active window only
`default_nettype none
`timescale 1ns/100ps

`include "video_downscale_consts.svh"

module video_downscale_tb
    import video_downscale_pkg::*;
;

    localparam int LINES     = 324;
    localparam int PIXELS    = 324;
    localparam int FRAME_CYC = 200 + LINES * (2 * PIXELS + 40);
    localparam int TIMEOUT   = 4 * FRAME_CYC + 2 * 1100 + 5000;

    logic        pclk;
    logic        resetn;
    logic        i_cam_de;
    logic        i_cam_vsync;
    logic [3:0]  i_cam_data;
    logic        i_rd_ack;
    logic        o_strobe_req;
    logic        o_obj_det;
    logic        o_obj_det_trg;
    logic        o_rd_req;
    logic        o_we;
    grid_addr_t  o_waddr;
    logic [15:0] o_dout;

    logic [7:0]  bg_pix [LINES][PIXELS];
    logic [7:0]  st_pix [LINES][PIXELS];
    logic [15:0] exp_img [2][1024];
    logic        exp_obj [2];
    logic [31:0] gen_lfsr = 32'ha3a53674;
    logic [31:0] ack_lfsr = 32'ha3a53674;
    int          err_main;
    int          err_data;
    int          err_hs;
    int          err_det;
    int          n_readouts;
    int          n_trg;
    int          wr_idx;
    int          writes_checked;
    int          cycles;

    video_downscale_top i_dut (.*);

    always #5 pclk = ~pclk;

    // ========================================
    // random source and reference model
    // ========================================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    task automatic take_bits(inout logic [31:0] st, input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v  = {v[30:0], st[0]};   // one step per bit
            st = lfsr_next(st);
        end
    endtask

    function automatic logic [7:0] block_mean(input logic use_st, input int r, input int c);
        int sum;
        int y;
        int x;
        sum = 0;
        for (int dy = 0; dy < `VD_BLOCK; dy++)
            for (int dx = 0; dx < `VD_BLOCK; dx++)
            begin
                y = `VD_Y0 + r * `VD_BLOCK + dy;
                x = `VD_X0 + c * `VD_BLOCK + dx;
                sum += int'(use_st ? st_pix[y][x] : bg_pix[y][x]);
            end
        return 8'((sum >> 7) + (sum >> 9));   // about sum/102.4
    endfunction

    task automatic build_expected(input int idx);
        logic [7:0] mb;
        logic [7:0] ms;
        logic [7:0] d;
        exp_obj[idx] = 1'b0;
        for (int r = 0; r < `VD_GRID; r++)
            for (int c = 0; c < `VD_GRID; c++)
            begin
                mb = block_mean(1'b0, r, c);
                ms = block_mean(1'b1, r, c);
                d  = (ms > mb) ? ms - mb : 8'd0;
                exp_img[idx][r * `VD_GRID + c] = 16'(4 * int'(d) - int'(`VD_DOUT_OFFSET));
                if (d >= 8'(`VD_OBJ_TH))
                    exp_obj[idx] = 1'b1;
            end
    endtask

    task automatic make_frames(input logic new_bg, input logic patch);
        logic [31:0] v;
        for (int y = 0; y < LINES; y++)
            for (int x = 0; x < PIXELS; x++)
            begin
                if (new_bg)
                begin
                    take_bits(gen_lfsr, 8, v);
                    bg_pix[y][x] = v[7:0];
                end
                st_pix[y][x] = bg_pix[y][x];
                if (patch && y >= 150 && y < 170 && x >= 150 && x < 170)   // bright 20x20
                    st_pix[y][x] = (bg_pix[y][x] > 8'd127) ? 8'hFF : bg_pix[y][x] + 8'd128;
            end
    endtask

    // ========================================
    // camera stream
    // ========================================
    task automatic send_frame(input logic use_st, input logic exp_strobe);
        logic [7:0] p;
        repeat (200)
        begin
            @(posedge pclk);
            i_cam_vsync <= 1'b1;
            i_cam_de    <= 1'b0;
        end
        for (int y = 0; y < LINES; y++)
        begin
            if (y == 10 && o_strobe_req !== exp_strobe)
            begin
                $display("ERR o_strobe_req exp %h got %h", exp_strobe, o_strobe_req);
                err_main++;
            end
            for (int x = 0; x < PIXELS; x++)
            begin
                p = use_st ? st_pix[y][x] : bg_pix[y][x];
                @(posedge pclk);
                i_cam_vsync <= 1'b0;
                i_cam_de    <= 1'b1;
                i_cam_data  <= p[7:4];   // upper nibble first
                @(posedge pclk);
                i_cam_data  <= p[3:0];
            end
            repeat (40)
            begin
                @(posedge pclk);
                i_cam_de <= 1'b0;
            end
        end
    endtask

    // ML engine answering the request after a random ack delay
    initial
    begin
        logic [31:0] dly;
        int          n_we;
        i_rd_ack   = 1'b0;
        n_readouts = 0;
        forever
        begin
            @(posedge pclk);
            if (resetn && o_rd_req && !i_rd_ack)
            begin
                take_bits(ack_lfsr, 4, dly);
                repeat (dly[3:0]) @(posedge pclk);
                i_rd_ack <= 1'b1;
                n_we      = 0;
                do
                begin
                    @(posedge pclk);
                    if (o_we)
                        n_we++;
                end
                while (o_rd_req);
                if (n_we != 1024)
                begin
                    $display("readout ended after %0d writes instead of 1024", n_we);
                    err_hs++;
                end
                i_rd_ack <= 1'b0;
                n_readouts++;
            end
        end
    end

    // compare each write with the reference image
    always @(posedge pclk)
    begin
        if (!o_rd_req)
            wr_idx = 0;
        if (resetn && o_we)
        begin
            if (!i_rd_ack)
            begin
                $display("write to the engine while ack was low");
                err_hs++;
            end
            if (n_readouts > 1)
            begin
                $display("write outside the two expected readouts");
                err_hs++;
            end
            else
            begin
                if (o_waddr !== 10'(wr_idx))
                begin
                    $display("ERR o_waddr exp %h got %h", 10'(wr_idx), o_waddr);
                    err_data++;
                end
                if (o_dout !== exp_img[n_readouts][wr_idx])
                begin
                    $display("ERR o_dout exp %h got %h", exp_img[n_readouts][wr_idx], o_dout);
                    err_data++;
                end
            end
            wr_idx++;
            writes_checked++;
        end
    end

    always @(posedge pclk)
    begin
        if (resetn && o_obj_det_trg)
        begin
            if (n_trg > 1)
            begin
                $display("unexpected extra o_obj_det_trg pulse");
                err_det++;
            end
            else if (o_obj_det !== exp_obj[n_trg])
            begin
                $display("ERR o_obj_det exp %h got %h", exp_obj[n_trg], o_obj_det);
                err_det++;
            end
            n_trg++;
        end
    end

    always @(posedge pclk)
    begin
        cycles++;
        if (cycles >= TIMEOUT)
        begin
            $display("timeout: readouts did not finish within %0d cycles", TIMEOUT);
            $display("Test failed");
            $finish;
        end
    end

    // ========================================
    // main sequence
    // ========================================
    initial
    begin
        int total;
        pclk           = 1'b0;
        resetn         = 1'b0;
        i_cam_de       = 1'b0;
        i_cam_vsync    = 1'b0;
        i_cam_data     = 4'h0;
        err_main       = 0;
        err_data       = 0;
        err_hs         = 0;
        err_det        = 0;
        n_trg          = 0;
        wr_idx         = 0;
        writes_checked = 0;
        cycles         = 0;
        repeat (4) @(posedge pclk);
        resetn <= 1'b1;
        @(posedge pclk);
        if (o_rd_req || o_we || o_obj_det || o_obj_det_trg || o_strobe_req)
        begin
            $display("outputs not low after reset");
            err_main++;
        end
        make_frames(1'b1, 1'b0);
        build_expected(0);
        send_frame(1'b0, 1'b0);
        send_frame(1'b1, 1'b1);
        make_frames(1'b1, 1'b1);
        build_expected(1);
        if (!exp_obj[1])
        begin
            $display("patch does not reach the object threshold in the reference");
            err_main++;
        end
        send_frame(1'b0, 1'b0);
        send_frame(1'b1, 1'b1);
        @(posedge pclk);
        i_cam_vsync <= 1'b1;   // idle in blanking
        while (n_readouts < 2)
            @(posedge pclk);
        repeat (50) @(posedge pclk);
        if (n_trg != 2)
        begin
            $display("saw %0d o_obj_det_trg pulses instead of 2", n_trg);
            err_main++;
        end
        total = err_main + err_data + err_hs + err_det;
        $display("errors %0d: data %0d, handshake %0d, detect %0d, other %0d; writes %0d",
                 total, err_data, err_hs, err_det, err_main, writes_checked);
        if (total == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/video_downscale_assertions.sv
// protocol checks on the ML-engine port; bound into the top level, sampled on pclk
`default_nettype none
`timescale 1ns/100ps

module video_downscale_assertions
    import video_downscale_pkg::*;
(
    input wire logic       pclk,
    input wire logic       resetn,
    input wire logic       i_rd_ack,
    input wire logic       o_rd_req,
    input wire logic       o_we,
    input wire grid_addr_t o_waddr
);

    // writes only inside a request
    a_we_in_req: assert property (@(posedge pclk) disable iff (!resetn) o_we |-> o_rd_req)
        else $error("o_we high without o_rd_req");

    a_req_hold: assert property (@(posedge pclk) disable iff (!resetn)
        (o_rd_req && !i_rd_ack) |=> o_rd_req)
        else $error("o_rd_req dropped before ack");

    a_waddr_inc: assert property (@(posedge pclk) disable iff (!resetn)
        (o_we ##1 o_we) |-> (o_waddr == $past(o_waddr) + 10'd1))
        else $error("o_waddr did not step by one");

endmodule

bind video_downscale_top video_downscale_assertions u_assertions (.*);

`default_nettype wire

//--- hw/video_downscale_top.sv
// single pclk domain; image store holds two strobe images so readout never races the writer
`default_nettype none
`timescale 1ns/100ps

`include "video_downscale_consts.svh"

module video_downscale_top
    import video_downscale_pkg::*;
(
    input  wire logic       pclk,
    input  wire logic       resetn,
    input  wire logic       i_cam_de,
    input  wire logic       i_cam_vsync,
    input  wire logic [3:0] i_cam_data,
    input  wire logic       i_rd_ack,
    output logic            o_strobe_req,
    output logic            o_obj_det,
    output logic            o_obj_det_trg,
    output logic            o_rd_req,
    output logic            o_we,
    output grid_addr_t      o_waddr,
    output logic [15:0]     o_dout
);

    timing_t     timing;
    block_res_t  blk;
    img_wr_t     img_wr;
    logic        img_done;
    logic        accept;
    logic [10:0] rd_addr;
    pix_t        rd_data;

    assign o_strobe_req = timing.strobe;   // strobe on for odd frames

    frame_timing u_frame_timing (
        .pclk        (pclk),
        .resetn      (resetn),
        .i_cam_de    (i_cam_de),
        .i_cam_vsync (i_cam_vsync),
        .o_timing    (timing)
    );

    block_accumulator u_block_acc (
        .pclk       (pclk),
        .resetn     (resetn),
        .i_timing   (timing),
        .i_cam_data (i_cam_data),
        .o_block    (blk)
    );

    strobe_compare u_strobe_cmp (
        .pclk          (pclk),
        .resetn        (resetn),
        .i_timing      (timing),
        .i_block       (blk),
        .i_accept      (accept),
        .o_img_wr      (img_wr),
        .o_img_done    (img_done),
        .o_obj_det     (o_obj_det),
        .o_obj_det_trg (o_obj_det_trg)
    );

    // ========================================
    // image store, two halves
    // ========================================
    dual_port_ram #(
        .data_t (pix_t),
        .DEPTH  (2 * `VD_GRID * `VD_GRID)
    ) u_img_ram (
        .pclk    (pclk),
        .i_we    (img_wr.we),
        .i_waddr ({img_wr.buf_sel, img_wr.addr}),
        .i_wdata (img_wr.data),
        .i_raddr (rd_addr),
        .o_rdata (rd_data)
    );

    readout_fsm u_readout (
        .pclk       (pclk),
        .resetn     (resetn),
        .i_img_done (img_done),
        .i_rd_ack   (i_rd_ack),
        .i_rd_data  (rd_data),
        .o_accept   (accept),
        .o_rd_addr  (rd_addr),
        .o_rd_req   (o_rd_req),
        .o_we       (o_we),
        .o_waddr    (o_waddr),
        .o_dout     (o_dout)
    );

endmodule

`default_nettype wire

//--- hw/readout_fsm.sv
// engine may only delay ack; the 1024-word stream never stalls once started
`default_nettype none
`timescale 1ns/100ps

`include "video_downscale_consts.svh"

module readout_fsm
    import video_downscale_pkg::*;
(
    input  wire logic  pclk,
    input  wire logic  resetn,
    input  wire logic  i_img_done,
    input  wire logic  i_rd_ack,
    input  wire pix_t  i_rd_data,
    output logic        o_accept,
    output logic [10:0] o_rd_addr,
    output logic        o_rd_req,
    output logic        o_we,
    output grid_addr_t  o_waddr,
    output logic [15:0] o_dout
);

    localparam logic [15:0] DOUT_OFS = 16'(`VD_DOUT_OFFSET);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_STREAM,
        ST_REL
    } state_t;

    state_t     state;
    logic       rd_buf;    // half of the image store being read
    grid_addr_t cnt;
    grid_addr_t waddr_d;
    logic       rd_vld;

    assign o_accept  = (state == ST_IDLE) && i_img_done;
    assign o_rd_addr = {rd_buf, cnt};

    // ========================================
    // handshake FSM
    // ========================================
    always_ff @(posedge pclk or negedge resetn)
    begin
        if (!resetn)
        begin
            state    <= ST_IDLE;
            rd_buf   <= 1'b1;   // flips to 0 for the first image
            cnt      <= '0;
            o_rd_req <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    cnt <= '0;
                    if (i_img_done)
                    begin
                        state    <= ST_REQ;
                        o_rd_req <= 1'b1;
                        rd_buf   <= ~rd_buf;   // mirrors the writer's toggle
                    end
                end
                ST_REQ:
                begin
                    if (i_rd_ack)
                        state <= ST_STREAM;
                end
                ST_STREAM:
                begin
                    cnt <= cnt + 10'd1;
                    if (cnt == '1)
                        state <= ST_REL;
                end
                ST_REL:
                begin
                    if (o_we && (o_waddr == '1))
                        o_rd_req <= 1'b0;   // after the last write
                    if (!o_rd_req && !i_rd_ack)
                        state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // read latency, then output register
    always_ff @(posedge pclk or negedge resetn)
    begin
        if (!resetn)
        begin
            rd_vld  <= 1'b0;
            o_we    <= 1'b0;
            o_waddr <= '0;
        end
        else
        begin
            rd_vld  <= (state == ST_STREAM);
            o_we    <= rd_vld;
            o_waddr <= waddr_d;
        end
    end

    always_ff @(posedge pclk)
    begin
        waddr_d <= cnt;
        if (rd_vld)
            o_dout <= (16'(i_rd_data) << 2) - DOUT_OFS;   // x4 minus offset
    end

endmodule

`default_nettype wire

//--- hw/strobe_compare.sv
// background must be captured in the preceding frame; mean is sum/102.4 by two shifts
`default_nettype none
`timescale 1ns/100ps

`include "video_downscale_consts.svh"

module strobe_compare
    import video_downscale_pkg::*;
(
    input  wire logic       pclk,
    input  wire logic       resetn,
    input  wire timing_t    i_timing,
    input  wire block_res_t i_block,
    input  wire logic       i_accept,
    output img_wr_t         o_img_wr,
    output logic            o_img_done,
    output logic            o_obj_det,
    output logic            o_obj_det_trg
);

    localparam pix_t       OBJ_TH    = pix_t'(`VD_OBJ_TH);
    localparam grid_addr_t LAST_ADDR = '1;

    pix_t       mean;
    pix_t       mean_q;
    pix_t       bg_rdata;
    pix_t       diff;
    grid_addr_t addr_q;
    logic       vld_q;
    logic       buf_sel;
    logic       obj_flag;
    logic       upd_q;
    logic       done_q;

    assign mean = pix_t'(i_block.sum >> 7) + pix_t'(i_block.sum >> 9);
    assign diff = (mean_q > bg_rdata) ? mean_q - bg_rdata : '0;   // clip at 0

    assign o_img_wr = '{we: vld_q && i_timing.strobe, buf_sel: buf_sel,
                        addr: addr_q, data: diff};

    assign o_img_done    = done_q;
    assign o_obj_det_trg = done_q;

    always_ff @(posedge pclk)
    begin
        if (i_block.valid)
        begin
            mean_q <= mean;
            addr_q <= i_block.addr;
        end
    end

    // ========================================
    // object flag and frame completion
    // ========================================
    always_ff @(posedge pclk or negedge resetn)
    begin
        if (!resetn)
        begin
            vld_q     <= 1'b0;
            buf_sel   <= 1'b0;
            obj_flag  <= 1'b0;
            upd_q     <= 1'b0;
            done_q    <= 1'b0;
            o_obj_det <= 1'b0;
        end
        else
        begin
            vld_q <= i_block.valid;
            if (i_accept)
                buf_sel <= ~buf_sel;   // reader owns the finished half
            if (i_timing.frame_start)
                obj_flag <= 1'b0;
            else if (o_img_wr.we && (diff >= OBJ_TH))
                obj_flag <= 1'b1;
            upd_q  <= o_img_wr.we && (addr_q == LAST_ADDR);
            done_q <= upd_q;
            if (upd_q)
                o_obj_det <= obj_flag;
        end
    end

    // background means, read while the sum is still in flight
    dual_port_ram #(
        .data_t (pix_t),
        .DEPTH  (`VD_GRID * `VD_GRID)
    ) u_bg_ram (
        .pclk    (pclk),
        .i_we    (vld_q && !i_timing.strobe),
        .i_waddr (addr_q),
        .i_wdata (mean_q),
        .i_raddr (i_block.addr),
        .o_rdata (bg_rdata)
    );

endmodule

`default_nettype wire

//--- hw/block_accumulator.sv
// camera data must arrive one cycle ahead of the timing struct; sums of one block line fit 16 bits
`default_nettype none
`timescale 1ns/100ps

`include "video_downscale_consts.svh"

module block_accumulator
    import video_downscale_pkg::*;
(
    input  wire logic       pclk,
    input  wire logic       resetn,
    input  wire timing_t    i_timing,
    input  wire logic [3:0] i_cam_data,
    output block_res_t      o_block
);

    localparam logic [3:0] LAST = 4'(`VD_BLOCK - 1);

    logic [3:0] nib_q;        // aligned with i_timing
    logic [3:0] hi_q;         // upper nibble
    pix_t       pixel;
    block_sum_t acc;
    block_sum_t base;
    block_sum_t ram_rdata;
    logic       first_q;
    logic       done_q;
    logic       last_line_q;
    logic [4:0] col_q;
    logic [4:0] row_q;

    assign pixel = {hi_q, nib_q};
    assign base  = (i_timing.blk_line == 4'd0) ? '0 : ram_rdata;   // new block row

    always_ff @(posedge pclk)
    begin
        nib_q <= i_cam_data;
        hi_q  <= nib_q;
        if (i_timing.pix_vld)
            acc <= (first_q ? base : acc) + block_sum_t'(pixel);
        if (i_timing.pix_vld && (i_timing.pix_x == LAST))
        begin
            col_q       <= i_timing.blk_col;
            row_q       <= i_timing.blk_row;
            last_line_q <= (i_timing.blk_line == LAST);
        end
    end

    always_ff @(posedge pclk or negedge resetn)
    begin
        if (!resetn)
        begin
            first_q <= 1'b0;
            done_q  <= 1'b0;
            o_block <= '0;
        end
        else
        begin
            first_q       <= i_timing.col_first;
            done_q        <= i_timing.pix_vld && (i_timing.pix_x == LAST);
            o_block.valid <= done_q && last_line_q;   // only the 10th line finishes a block
            o_block.addr  <= {row_q, col_q};
            o_block.sum   <= acc;
        end
    end

    // partial sums, one per block column
    dual_port_ram #(
        .data_t (block_sum_t),
        .DEPTH  (`VD_GRID)
    ) u_line_ram (
        .pclk    (pclk),
        .i_we    (done_q),
        .i_waddr (col_q),
        .i_wdata (acc),
        .i_raddr (i_timing.blk_col),   // read lands on the first pixel
        .o_rdata (ram_rdata)
    );

endmodule

`default_nettype wire

//--- hw/frame_timing.sv
// expects nibble pairs upper first while de is high; window origin and size come from the consts header
`default_nettype none
`timescale 1ns/100ps

`include "video_downscale_consts.svh"

module frame_timing
    import video_downscale_pkg::*;
(
    input  wire logic pclk,
    input  wire logic resetn,
    input  wire logic i_cam_de,
    input  wire logic i_cam_vsync,
    output timing_t   o_timing
);

    localparam int         WIN  = `VD_BLOCK * `VD_GRID;
    localparam logic [8:0] X_LO = 9'(`VD_X0);
    localparam logic [8:0] X_HI = 9'(`VD_X0 + WIN);
    localparam logic [8:0] Y_LO = 9'(`VD_Y0);
    localparam logic [8:0] Y_HI = 9'(`VD_Y0 + WIN);
    localparam logic [3:0] LAST = 4'(`VD_BLOCK - 1);

    logic       de_q;
    logic       vsync_q;
    logic       frame_idx;
    logic [9:0] nib_cnt;   // bit 0 selects lower nibble
    logic [8:0] line_cnt;
    logic [3:0] px;
    logic [4:0] bc;
    logic [3:0] bl;
    logic [4:0] br;
    logic       h_win;
    logic       v_win;
    logic       act;
    logic       line_end;
    logic       fs;

    // ========================================
    // window masks
    // ========================================
    assign h_win    = (nib_cnt[9:1] >= X_LO) && (nib_cnt[9:1] < X_HI);
    assign v_win    = (line_cnt >= Y_LO) && (line_cnt < Y_HI);
    assign act      = i_cam_de && h_win && v_win;
    assign line_end = de_q && !i_cam_de;
    assign fs       = vsync_q && !i_cam_vsync;

    // ========================================
    // line and frame counters
    // ========================================
    always_ff @(posedge pclk or negedge resetn)
    begin
        if (!resetn)
        begin
            de_q      <= 1'b0;
            vsync_q   <= 1'b0;
            frame_idx <= 1'b1;   // first frame after reset is background
            nib_cnt   <= '0;
            line_cnt  <= '0;
        end
        else
        begin
            de_q    <= i_cam_de;
            vsync_q <= i_cam_vsync;
            nib_cnt <= i_cam_de ? nib_cnt + 10'd1 : 10'd0;
            if (i_cam_vsync)
                line_cnt <= '0;
            else if (line_end)
                line_cnt <= line_cnt + 9'd1;
            if (fs)
                frame_idx <= ~frame_idx;
        end
    end

    // block position of the current nibble
    always_ff @(posedge pclk or negedge resetn)
    begin
        if (!resetn)
        begin
            px <= '0;
            bc <= '0;
            bl <= '0;
            br <= '0;
        end
        else
        begin
            if (!i_cam_de)
            begin
                px <= '0;
                bc <= '0;
            end
            else if (act && nib_cnt[0])
            begin
                px <= (px == LAST) ? 4'd0 : px + 4'd1;
                if (px == LAST)
                    bc <= bc + 5'd1;   // wraps to 0 after the last column
            end
            if (i_cam_vsync)
            begin
                bl <= '0;
                br <= '0;
            end
            else if (line_end && v_win)
            begin
                bl <= (bl == LAST) ? 4'd0 : bl + 4'd1;
                if (bl == LAST)
                    br <= br + 5'd1;
            end
        end
    end

    always_ff @(posedge pclk or negedge resetn)
    begin
        if (!resetn)
            o_timing <= '0;
        else
        begin
            o_timing.frame_start <= fs;
            if (fs)
                o_timing.strobe <= ~frame_idx;   // held for the whole frame
            o_timing.pix_vld   <= act && nib_cnt[0];
            o_timing.col_first <= act && !nib_cnt[0] && (px == 4'd0);
            o_timing.blk_col   <= bc;
            o_timing.blk_row   <= br;
            o_timing.blk_line  <= bl;
            o_timing.pix_x     <= px;
        end
    end

endmodule

`default_nettype wire

//--- hw/dual_port_ram.sv
// one write port and one registered read port on pclk; contents are undefined after power-up
`default_nettype none
`timescale 1ns/100ps

module dual_port_ram #(
    parameter type data_t = logic [7:0],
    parameter int  DEPTH  = 256
) (
    input  wire logic                     pclk,
    input  wire logic                     i_we,
    input  wire logic [$clog2(DEPTH)-1:0] i_waddr,
    input  wire data_t                    i_wdata,
    input  wire logic [$clog2(DEPTH)-1:0] i_raddr,
    output data_t                         o_rdata
);

    data_t mem [DEPTH];

    always_ff @(posedge pclk)
    begin
        if (i_we)
        begin
            mem[i_waddr] <= i_wdata;
        end
        o_rdata <= mem[i_raddr];   // one cycle read latency
    end

endmodule

`default_nettype wire

//--- hw/video_downscale_pkg.sv
// shared types for the downscaler; grid coordinates are 5 bits, so the grid edge is 32
`default_nettype none

`include "video_downscale_consts.svh"

package video_downscale_pkg;

    typedef logic [`VD_PIX_W-1:0] pix_t;
    typedef logic [15:0]          block_sum_t;   // 100 pixels of 8 bits fit
    typedef logic [9:0]           grid_addr_t;   // {row, col}

    // per-nibble timing from the camera counters
    typedef struct packed {
        logic       frame_start;   // one cycle at vsync falling
        logic       strobe;        // frame parity
        logic       pix_vld;       // lower nibble of an active pixel
        logic       col_first;     // upper nibble, first pixel of a block column
        logic [4:0] blk_col;
        logic [4:0] blk_row;
        logic [3:0] blk_line;      // line within the block
        logic [3:0] pix_x;         // pixel within the block
    } timing_t;

    typedef struct packed {
        logic       valid;
        grid_addr_t addr;
        block_sum_t sum;
    } block_res_t;

    typedef struct packed {
        logic       we;
        logic       buf_sel;       // image buffer half
        grid_addr_t addr;
        pix_t       data;
    } img_wr_t;

endpackage

`default_nettype wire

//--- include/video_downscale_consts.svh
// compile-time geometry only; window must fit the line and grid edge must stay at 32
`ifndef VIDEO_DOWNSCALE_CONSTS_SVH
`define VIDEO_DOWNSCALE_CONSTS_SVH

// ========================================
// pixel and block geometry
// ========================================
`define VD_PIX_W        8           // two camera nibbles per pixel
`define VD_BLOCK        10          // block edge in pixels
`define VD_GRID         32          // blocks per row and per column

// ========================================
// active window origin
// ========================================
`define VD_X0           1           // first active pixel of a line
`define VD_Y0           2           // first active line after vsync

// ========================================
// detection and output format
// ========================================
`define VD_OBJ_TH       30          // difference that counts as an object
`define VD_DOUT_OFFSET  16'h0200    // subtracted after the x4 scaling

`endif
